// ==== src/amo_pkg.sv ====
// --------------------
// Atomic operation encoding, shared by RTL and testbench
// Atomics are 32 bits wide on a 32- or 64-bit bus
// --------------------
package amo_pkg;

    // Width of one atomic operand
    localparam int unsigned AmoWidth = 32;
    localparam int unsigned AmoBytes = AmoWidth / 8;  // Byte lanes per atomic word

    // --------------------
    // Operation encoding
    // --------------------
    // Values follow the request-side amo_i field
    typedef enum logic [3:0] {
        AmoNone = 4'h0,  // Plain load or store
        AmoSwap = 4'h1,
        AmoAdd  = 4'h2,
        AmoAnd  = 4'h3,
        AmoOr   = 4'h4,
        AmoXor  = 4'h5,
        AmoMax  = 4'h6,  // Signed
        AmoMaxu = 4'h7,  // Unsigned
        AmoMin  = 4'h8,  // Signed
        AmoMinu = 4'h9,  // Unsigned
        AmoCas  = 4'hA   // Compare-and-swap, lower word only
    } amo_op_t;

    // Codes 0xB to 0xF are unused and act like AmoNone in the ALU

endpackage

// ==== src/bank_if.sv ====
// --------------------
// Memory stage port, single master and single slave
// Slave accepts every request, read data one cycle later
// --------------------
interface bank_if #(
    parameter int unsigned AddrWidth = 8,
    parameter int unsigned DataWidth = 64
) ();

    logic                   req;    // Access strobe
    logic [AddrWidth-1:0]   addr;   // Word address
    logic                   wen;    // 1 store, 0 load
    logic [DataWidth-1:0]   wdata;
    logic [DataWidth/8-1:0] be;     // Byte enables, used on stores
    logic [DataWidth-1:0]   rdata;  // Valid the cycle after a load

    // Request side
    modport master (
        output req, addr, wen, wdata, be,
        input  rdata
    );

    // Memory side
    modport slave (
        input  req, addr, wen, wdata, be,
        output rdata
    );

endinterface

// ==== src/amo_alu.sv ====
// --------------------
// New memory word for one atomic, purely combinational
// Unknown op codes leave the word unchanged
// --------------------
module amo_alu (
    input  amo_pkg::amo_op_t              op_i,
    input  logic [amo_pkg::AmoWidth-1:0]  mem_i,      // Old word
    input  logic [amo_pkg::AmoWidth-1:0]  operand_i,  // Operand, or compare value for CAS
    input  logic [amo_pkg::AmoWidth-1:0]  swap_i,     // New value for CAS
    output logic [amo_pkg::AmoWidth-1:0]  result_o
);

    import amo_pkg::*;

    // --------------------
    // Shared adder
    // --------------------
    // One extra bit so that the sign of a difference never overflows
    logic [AmoWidth:0] adder_a;
    logic [AmoWidth:0] adder_b;
    logic [AmoWidth:0] adder_b_raw;
    logic [AmoWidth:0] adder_sum;
    logic              subtract;
    logic              sign_ext;  // Signed compare
    logic              mem_less;  // mem_i below operand_i
    logic              mem_equal;

    assign subtract = (op_i != AmoAdd);
    assign sign_ext = (op_i == AmoMax) || (op_i == AmoMin);

    assign adder_a     = {sign_ext & mem_i[AmoWidth-1], mem_i};
    assign adder_b_raw = {sign_ext & operand_i[AmoWidth-1], operand_i};
    assign adder_b     = subtract ? ~adder_b_raw : adder_b_raw;

    // Two's complement subtract via inverted operand plus carry in
    assign adder_sum = adder_a + adder_b + {{AmoWidth{1'b0}}, subtract};

    assign mem_less  = adder_sum[AmoWidth];
    assign mem_equal = (adder_sum == '0);

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        result_o = mem_i;  // None and unused codes

        unique case (op_i)
            AmoSwap: result_o = operand_i;
            AmoAdd:  result_o = adder_sum[AmoWidth-1:0];
            AmoAnd:  result_o = mem_i & operand_i;
            AmoOr:   result_o = mem_i | operand_i;
            AmoXor:  result_o = mem_i ^ operand_i;
            AmoMax,
            AmoMaxu: begin
                result_o = mem_less ? operand_i : mem_i;
            end
            AmoMin,
            AmoMinu: begin
                result_o = mem_less ? mem_i : operand_i;
            end
            AmoCas: begin
                // Replace only on a matching compare value
                result_o = mem_equal ? swap_i : mem_i;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/amo_shim.sv ====
// --------------------
// Atomic shim, needs exclusive access to the bank behind it
// DataWidth 32 or 64; CAS is lower word only and a no-op at 32
// --------------------
module amo_shim #(
    parameter int unsigned AddrWidth = 8,
    parameter int unsigned DataWidth = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Requester side
    input  logic                   req_i,
    output logic                   gnt_o,    // Low while an atomic writes back
    input  logic [AddrWidth-1:0]   addr_i,
    input  amo_pkg::amo_op_t       amo_i,
    input  logic                   wen_i,    // 1 store, 0 load
    input  logic [DataWidth-1:0]   wdata_i,
    input  logic [DataWidth/8-1:0] be_i,
    output logic [DataWidth-1:0]   rdata_o,
    // Memory side
    bank_if.master                 mem
);

    import amo_pkg::*;

    typedef enum logic {
        Idle,
        DoAmo
    } state_e;

    state_e state_q;

    logic load_amo;  // Atomic accepted this cycle

    // Captured atomic request
    amo_op_t                op_q;
    logic [AddrWidth-1:0]   addr_q;
    logic                   upper_q;    // Upper word selected
    logic [AmoWidth-1:0]    operand_q;
    logic [AmoWidth-1:0]    swap_q;

    // Word select, per bus width
    logic                   upper_in;
    logic [AmoWidth-1:0]    operand_in;
    logic [AmoWidth-1:0]    swap_in;
    logic [AmoWidth-1:0]    old_word;
    logic [DataWidth-1:0]   amo_wdata;
    logic [DataWidth/8-1:0] amo_be;
    logic [DataWidth-1:0]   amo_rdata;

    amo_op_t             alu_op;
    logic [AmoWidth-1:0] alu_result;

    // --------------------
    // Word select
    // --------------------
    if (DataWidth == 64) begin : gen_wide
        assign upper_in   = be_i[4];
        assign operand_in = be_i[4] ? wdata_i[63:32] : wdata_i[31:0];
        assign swap_in    = wdata_i[63:32];  // CAS swap value rides in the upper half

        assign old_word  = upper_q ? mem.rdata[63:32] : mem.rdata[31:0];
        assign amo_wdata = upper_q ? {alu_result, {AmoWidth{1'b0}}}
                                   : {{AmoWidth{1'b0}}, alu_result};
        assign amo_be    = upper_q ? {{AmoBytes{1'b1}}, {AmoBytes{1'b0}}}
                                   : {{AmoBytes{1'b0}}, {AmoBytes{1'b1}}};
        assign amo_rdata = upper_q ? {old_word, {AmoWidth{1'b0}}}
                                   : {{AmoWidth{1'b0}}, old_word};
    end else begin : gen_narrow
        // Single word, no select and no room for a swap value
        assign upper_in   = 1'b0;
        assign operand_in = wdata_i;
        assign swap_in    = '0;

        assign old_word  = mem.rdata;
        assign amo_wdata = alu_result;
        assign amo_be    = '1;
        assign amo_rdata = old_word;
    end

    // CAS degrades to a plain write-back of the old word at 32 bits
    assign alu_op = (DataWidth == 32 && op_q == AmoCas) ? AmoNone : op_q;

    amo_alu i_amo_alu (
        .op_i      (alu_op),
        .mem_i     (old_word),
        .operand_i (operand_q),
        .swap_i    (swap_q),
        .result_o  (alu_result)
    );

    // --------------------
    // Request steering
    // --------------------
    always_comb begin
        // Pass-through by default
        mem.req   = req_i;
        mem.addr  = addr_i;
        mem.wen   = wen_i;
        mem.wdata = wdata_i;
        mem.be    = be_i;
        gnt_o     = req_i;
        rdata_o   = mem.rdata;
        load_amo  = 1'b0;

        unique case (state_q)
            Idle: begin
                if (req_i && amo_i != AmoNone) begin
                    load_amo = 1'b1;
                    mem.wen  = 1'b0;  // Atomic starts as a read
                end
            end
            DoAmo: begin
                // Bank belongs to the write-back this cycle
                gnt_o     = 1'b0;
                mem.req   = 1'b1;
                mem.addr  = addr_q;
                mem.wen   = 1'b1;
                mem.wdata = amo_wdata;
                mem.be    = amo_be;
                rdata_o   = amo_rdata;
            end
            default: ;
        endcase
    end

    // Write-back always lasts exactly one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Idle;
        end else begin
            state_q <= load_amo ? DoAmo : Idle;
        end
    end

    // Atomic request capture
    always_ff @(posedge clk_i) begin
        if (load_amo) begin
            op_q      <= amo_i;
            addr_q    <= addr_i;
            upper_q   <= upper_in;
            operand_q <= operand_in;
            swap_q    <= swap_in;
        end
    end

endmodule

// ==== src/sram_bank.sv ====
// --------------------
// Single-port SRAM, one cycle read latency
// Contents undefined after power-up
// --------------------
module sram_bank #(
    parameter int unsigned AddrWidth = 8,
    parameter int unsigned DataWidth = 64
) (
    input  logic   clk_i,
    bank_if.slave  mem
);

    localparam int unsigned NumWords = 2 ** AddrWidth;
    localparam int unsigned NumBytes = DataWidth / 8;

    logic [DataWidth-1:0] ram_q [NumWords];
    logic [DataWidth-1:0] rdata_q;

    // --------------------
    // Memory stage
    // --------------------
    always_ff @(posedge clk_i) begin
        if (mem.req) begin
            if (mem.wen) begin
                // Only enabled byte lanes change
                for (int unsigned i = 0; i < NumBytes; i++) begin
                    if (mem.be[i]) begin
                        ram_q[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= ram_q[mem.addr];  // Old word, out next cycle
            end
        end
    end

    // Holds the last read until the next load
    assign mem.rdata = rdata_q;

endmodule

// ==== src/amo_mem_top.sv ====
// --------------------
// Atomic memory bank, shim in front of one SRAM
// Hold req_i until gnt_o; rdata_o one cycle after grant
// --------------------
module amo_mem_top #(
    parameter int unsigned AddrWidth = 8,   // Bank holds 2**AddrWidth words
    parameter int unsigned DataWidth = 64   // 32 or 64
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Requester port
    input  logic                   req_i,    // Held until granted
    output logic                   gnt_o,
    input  logic [AddrWidth-1:0]   addr_i,   // Word address
    input  amo_pkg::amo_op_t       amo_i,    // AmoNone for plain access
    input  logic                   wen_i,    // 1 store, 0 load
    input  logic [DataWidth-1:0]   wdata_i,
    input  logic [DataWidth/8-1:0] be_i,     // Bit 4 picks the upper atomic word
    output logic [DataWidth-1:0]   rdata_o   // Loads and atomics
);

    // --------------------
    // Shim to SRAM link
    // --------------------
    bank_if #(
        .AddrWidth (AddrWidth),
        .DataWidth (DataWidth)
    ) bank_bus ();

    // Request stage
    amo_shim #(
        .AddrWidth (AddrWidth),
        .DataWidth (DataWidth)
    ) i_amo_shim (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (req_i),
        .gnt_o   (gnt_o),
        .addr_i  (addr_i),
        .amo_i   (amo_i),
        .wen_i   (wen_i),
        .wdata_i (wdata_i),
        .be_i    (be_i),
        .rdata_o (rdata_o),
        .mem     (bank_bus.master)
    );

    // Memory stage
    sram_bank #(
        .AddrWidth (AddrWidth),
        .DataWidth (DataWidth)
    ) i_sram_bank (
        .clk_i (clk_i),
        .mem   (bank_bus.slave)
    );

endmodule

// ==== test/tb_amo_mem.sv ====
// --------------------
// Testbench for the atomic memory bank, default parameters (64-bit bus)
// Shadow memory model; every word is written before it is read
// --------------------
module tb_amo_mem;

    import amo_pkg::*;

    localparam int NumWindow   = 16;   // Preloaded words for the random mix
    localparam int NumDirected = 100;
    localparam int NumRandom   = 300;
    localparam int TimeoutCycles = 4 * (NumWindow + NumDirected + NumRandom) + 100;

    localparam amo_op_t LogicOps [5] = '{AmoSwap, AmoAdd, AmoAnd, AmoOr, AmoXor};
    localparam amo_op_t MaxMinOps [4] = '{AmoMax, AmoMaxu, AmoMin, AmoMinu};
    // Old word against operand: sign differs, equal, extremes
    localparam logic [31:0] PairMem [4] = '{32'h0000_0001, 32'h1234_5678,
                                            32'h7FFF_FFFF, 32'h8000_0000};
    localparam logic [31:0] PairOpd [4] = '{32'hFFFF_FFFF, 32'h1234_5678,
                                            32'h8000_0000, 32'h0000_0000};

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        req_i;
    logic        gnt_o;
    logic [7:0]  addr_i;
    amo_op_t     amo_i;
    logic        wen_i;
    logic [63:0] wdata_i;
    logic [7:0]  be_i;
    logic [63:0] rdata_o;

    logic [63:0] shadow [256];   // Reference memory
    logic [63:0] expected_q [$];
    logic        amo_busy;       // Atomic granted in the previous cycle
    int          cycle_count;

    amo_mem_top i_amo_mem_top (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (req_i),
        .gnt_o   (gnt_o),
        .addr_i  (addr_i),
        .amo_i   (amo_i),
        .wen_i   (wen_i),
        .wdata_i (wdata_i),
        .be_i    (be_i),
        .rdata_o (rdata_o)
    );

    always #5 clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // New memory word for one atomic
    function automatic logic [31:0] amo_ref(input amo_op_t op, input logic [31:0] old,
                                            input logic [31:0] operand,
                                            input logic [31:0] swap);
        case (op)
            AmoSwap: return operand;
            AmoAdd:  return old + operand;
            AmoAnd:  return old & operand;
            AmoOr:   return old | operand;
            AmoXor:  return old ^ operand;
            AmoMax:  return ($signed(old) > $signed(operand)) ? old : operand;
            AmoMaxu: return (old > operand) ? old : operand;
            AmoMin:  return ($signed(old) < $signed(operand)) ? old : operand;
            AmoMinu: return (old < operand) ? old : operand;
            AmoCas:  return (old == operand) ? swap : old;
            default: return old;
        endcase
    endfunction

    // Holds one request until granted, then updates the model
    task automatic issue(input logic [7:0] addr, input amo_op_t op, input logic wen,
                         input logic [63:0] wdata, input logic [7:0] be);
        logic        granted;
        logic        exp_gnt;
        logic        upper;
        logic [31:0] old_word;
        logic [31:0] operand;
        logic [31:0] new_word;
        granted = 1'b0;
        while (!granted) begin
            @(negedge clk_i);
            req_i   = 1'b1;
            addr_i  = addr;
            amo_i   = op;
            wen_i   = wen;
            wdata_i = wdata;
            be_i    = be;
            #1;
            exp_gnt = !amo_busy;  // Grant withheld only during write-back
            assert (gnt_o === exp_gnt) else
                stop_on_error($sformatf("FAIL gnt_o expected %h got %h", exp_gnt, gnt_o));
            amo_busy = 1'b0;
            granted  = gnt_o;
        end
        amo_busy = (op != AmoNone);
        if (op == AmoNone) begin
            if (wen) begin
                for (int i = 0; i < 8; i++) begin
                    if (be[i]) shadow[addr][8*i +: 8] = wdata[8*i +: 8];
                end
            end else begin
                expected_q.push_back(shadow[addr]);
            end
        end else begin
            upper    = be[4];
            old_word = upper ? shadow[addr][63:32] : shadow[addr][31:0];
            operand  = upper ? wdata[63:32] : wdata[31:0];
            new_word = amo_ref(op, old_word, operand, wdata[63:32]);
            if (upper) shadow[addr][63:32] = new_word;
            else       shadow[addr][31:0]  = new_word;
            expected_q.push_back(upper ? {old_word, 32'h0} : {32'h0, old_word});
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk_i);
        req_i = 1'b0;
        amo_i = AmoNone;
        wen_i = 1'b0;
        #1;
        assert (gnt_o === 1'b0) else
            stop_on_error($sformatf("FAIL gnt_o expected %h got %h", 1'b0, gnt_o));
        amo_busy = 1'b0;
    endtask

    task automatic write_word(input logic [7:0] addr, input logic [63:0] data,
                              input logic [7:0] be);
        issue(addr, AmoNone, 1'b1, data, be);
    endtask

    task automatic read_word(input logic [7:0] addr);
        issue(addr, AmoNone, 1'b0, 64'h0, 8'hFF);
    endtask

    task automatic do_amo(input logic [7:0] addr, input amo_op_t op,
                          input logic [63:0] wdata, input logic upper);
        issue(addr, op, 1'b0, wdata, upper ? 8'hF0 : 8'h0F);
    endtask

    // --------------------
    // Comparator
    // --------------------
    initial begin
        logic [63:0] exp_data;
        forever begin
            @(posedge clk_i);
            #3;  // Mid cycle, rdata_o settled
            if (expected_q.size() > 0) begin
                exp_data = expected_q.pop_front();
                assert (rdata_o === exp_data) else
                    stop_on_error($sformatf("FAIL rdata_o expected %h got %h",
                                            exp_data, rdata_o));
            end
        end
    end

    // Timeout
    initial begin
        cycle_count = 0;
        while (cycle_count < TimeoutCycles) begin
            @(posedge clk_i);
            cycle_count++;
        end
        stop_on_error("Timeout, the run did not finish in time");
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [31:0] rng;
        logic [31:0] sel;
        logic [31:0] data_lo;
        logic [31:0] data_hi;
        logic [7:0]  addr;
        logic        upper;
        int unsigned kind;
        amo_op_t     op;
        rst_ni   = 1'b0;
        req_i    = 1'b0;
        addr_i   = '0;
        amo_i    = AmoNone;
        wen_i    = 1'b0;
        wdata_i  = '0;
        be_i     = '0;
        amo_busy = 1'b0;
        rng      = 32'd56423;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;

        // Preload the random window, pattern from the full address
        for (int a = 0; a < NumWindow; a++) begin
            addr = 8'h40 + 8'(a);
            write_word(addr, {addr, 8'hA5, ~addr, 8'h3C, addr, 8'h96, ~addr, 8'h0F}, 8'hFF);
        end

        // Plain stores, byte merges, loads
        write_word(8'h10, 64'h0123_4567_89AB_CDEF, 8'hFF);
        write_word(8'h11, 64'hFEDC_BA98_7654_3210, 8'hFF);
        write_word(8'h12, 64'h1111_2222_3333_4444, 8'hFF);
        write_word(8'h10, 64'hAAAA_AAAA_BBBB_BBBB, 8'h0F);
        write_word(8'h11, 64'hCCCC_CCCC_DDDD_DDDD, 8'hA5);
        write_word(8'h12, 64'hEE00_0000_0000_0000, 8'h80);
        read_word(8'h10);
        read_word(8'h11);
        read_word(8'h12);

        // Swap, add and bitwise ops on both halves
        for (int k = 0; k < 5; k++) begin
            for (int h = 0; h < 2; h++) begin
                write_word(8'h20, 64'hF0F0_1234_0F0F_8765, 8'hFF);
                do_amo(8'h20, LogicOps[k], 64'h3C3C_0101_5A5A_F00F, h == 1);
                read_word(8'h20);
            end
        end

        // Max and min, alternating halves
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 4; k++) begin
                write_word(8'h21, {PairMem[p], PairMem[p]}, 8'hFF);
                do_amo(8'h21, MaxMinOps[k], {PairOpd[p], PairOpd[p]}, p[0]);
                read_word(8'h21);
            end
        end

        // CAS on the lower word, hit then miss
        write_word(8'h30, 64'hCAFE_F00D_0000_1111, 8'hFF);
        do_amo(8'h30, AmoCas, 64'hBEEF_0001_0000_1111, 1'b0);
        read_word(8'h30);
        do_amo(8'h30, AmoCas, 64'h5555_AAAA_0000_2222, 1'b0);
        read_word(8'h30);

        // Back-to-back atomics on one address
        write_word(8'h31, 64'h8000_0000_0000_00FF, 8'hFF);
        do_amo(8'h31, AmoAdd, 64'h0000_0000_0000_0001, 1'b0);
        do_amo(8'h31, AmoAdd, 64'h0000_0000_0000_0002, 1'b0);
        do_amo(8'h31, AmoXor, 64'hFFFF_0000_0000_0000, 1'b1);
        do_amo(8'h31, AmoSwap, 64'h0000_0000_1234_5678, 1'b0);
        read_word(8'h31);
        do_amo(8'h31, AmoMax, 64'h7000_0000_0000_0000, 1'b1);
        read_word(8'h31);

        // Random mix in the preloaded window
        for (int n = 0; n < NumRandom; n++) begin
            rng     = xorshift(rng);
            sel     = rng;
            rng     = xorshift(rng);
            data_lo = rng;
            rng     = xorshift(rng);
            data_hi = rng;
            kind    = sel % 12;
            addr    = {4'h4, sel[7:4]};
            upper   = sel[16];
            if (kind == 0) begin
                read_word(addr);
            end else if (kind == 1) begin
                write_word(addr, {data_hi, data_lo}, sel[15:8]);
            end else begin
                op = amo_op_t'(4'(kind - 1));
                if (op == AmoCas) begin
                    upper = 1'b0;
                    if (sel[17]) data_lo = shadow[addr][31:0];  // Force a match
                end
                do_amo(addr, op, {data_hi, data_lo}, upper);
            end
            if (sel[31:29] == 3'b000) idle_cycle();
        end

        // Drain the last responses
        repeat (4) idle_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/amo_pkg.sv
src/bank_if.sv
src/amo_alu.sv
src/amo_shim.sv
src/sram_bank.sv
src/amo_mem_top.sv
test/tb_amo_mem.sv

// ==== Makefile ====
# Verilator build for the atomic memory bank testbench
# The run target fails when the simulation ends with $fatal

TOP := tb_amo_mem

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f src/*.sv test/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
